// ==== list.f ====
+incdir+common
common/valu_pkg.sv
simd_alu/simd_alu.sv
hw/result_fifo.sv
hw/insn_queue.sv
hw/valu_issue.sv
hw/valu_top.sv
sim/tb_valu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds tb_valu with Verilator, runs it and scans the log for a failure
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_valu -f list.f -o tb_valu
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/tb_valu > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
exit 0

// ==== sim/tb_valu.sv ====
// Directed testbench for valu_top; operands and grants are driven on the falling edge, 3000-cycle cap
`timescale 1ns/1ps
`include "valu_settings.svh"

module tb_valu;

  // Roughly ten times the cycles the directed tests need
  localparam int unsigned TimeoutCycles = 3000;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  valu_pkg::valu_insn_t   insn_i;
  logic                   insn_valid_i, insn_ready_o;
  valu_pkg::elen_t        operand_a_i, operand_b_i;
  logic                   operand_a_valid_i, operand_a_ready_o;
  logic                   operand_b_valid_i, operand_b_ready_o;
  valu_pkg::strb_t        mask_i;
  logic                   mask_valid_i, mask_ready_o;
  valu_pkg::valu_result_t result_o;
  logic                   result_req_o, result_gnt_i;
  logic [`VALU_NR_IDS-1:0] done_o;

  // Pending stimulus, the front of each queue sits on the bus
  valu_pkg::valu_insn_t   insn_q[$];
  valu_pkg::elen_t        a_q[$];
  valu_pkg::elen_t        b_q[$];
  valu_pkg::strb_t        m_q[$];
  // Expected responses in arrival order
  valu_pkg::valu_result_t exp_res_q[$];
  valu_pkg::vid_t         exp_done_q[$];
  logic                   hold_gnt = 1'b0;
  logic [31:0]            lcg_state = 32'd32;
  string                  cur_test = "reset";
  int unsigned            errors = 0;
  int unsigned            checks = 0;
  int unsigned            tests = 0;
  int unsigned            errors_before = 0;

  valu_top i_dut (.*);

  always #4 clk_i = ~clk_i;

  // Present queue fronts, grant whenever a request is up and not held off
  always @(negedge clk_i) begin : feed_inputs
    insn_valid_i      = (insn_q.size() != 0);
    operand_a_valid_i = (a_q.size() != 0);
    operand_b_valid_i = (b_q.size() != 0);
    mask_valid_i      = (m_q.size() != 0);
    if (insn_q.size() != 0) insn_i = insn_q[0];
    if (a_q.size() != 0) operand_a_i = a_q[0];
    if (b_q.size() != 0) operand_b_i = b_q[0];
    if (m_q.size() != 0) mask_i = m_q[0];
    result_gnt_i = result_req_o && !hold_gnt;
  end

  // Retire consumed words and check what the DUT hands out
  always @(posedge clk_i) begin : watch_outputs
    if (rst_ni) begin
      if (insn_valid_i && insn_ready_o) insn_q.delete(0);
      if (operand_a_valid_i && operand_a_ready_o) a_q.delete(0);
      if (operand_b_valid_i && operand_b_ready_o) b_q.delete(0);
      if (mask_valid_i && mask_ready_o) m_q.delete(0);
      if (result_req_o && result_gnt_i) begin
        if (exp_res_q.size() == 0) begin
          note_failure("a result word was granted while none was expected");
        end else begin
          check_result(cur_test, exp_res_q[0], result_o);
          exp_res_q.delete(0);
        end
      end
      if (done_o != '0) begin
        if (exp_done_q.size() == 0) begin
          note_failure("a done pulse appeared while none was expected");
        end else begin
          check_done(cur_test, exp_done_q[0], done_o);
          exp_done_q.delete(0);
        end
      end
    end
  end

  // Numerical Recipes LCG constants
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic valu_pkg::elen_t rand_word();
    logic [31:0] hi;
    hi = lcg_next();
    return {hi, lcg_next()};
  endfunction

  function automatic int unsigned elem_bytes(input valu_pkg::vsew_e sew);
    case (sew)
      valu_pkg::EW8:  return 1;
      valu_pkg::EW16: return 2;
      valu_pkg::EW32: return 4;
      default:        return 8;
    endcase
  endfunction

  function automatic valu_pkg::valu_insn_t make_insn(
    input valu_pkg::vid_t    id,
    input valu_pkg::alu_op_e op,
    input valu_pkg::vsew_e   sew,
    input valu_pkg::vlen_t   vl,
    input valu_pkg::vreg_t   vd,
    input logic              vm,
    input valu_pkg::elen_t   scalar = '0,
    input logic              use_scalar = 1'b0
  );
    return '{id: id, op: op, vsew: sew, vl: vl, vd: vd,
             scalar_op: scalar, use_scalar: use_scalar, vm: vm};
  endfunction

  // Reference for one result word, element by element
  function automatic valu_pkg::valu_result_t model_word(
    input valu_pkg::valu_insn_t insn,
    input valu_pkg::elen_t      a,
    input valu_pkg::elen_t      b,
    input valu_pkg::strb_t      m,
    input int unsigned          widx
  );
    valu_pkg::valu_result_t r;
    int unsigned ebytes;
    int unsigned nelem;
    int unsigned sh;
    logic [63:0] emask, x, y, z;
    logic        lt_s, lt_u;
    ebytes  = elem_bytes(insn.vsew);
    nelem   = 8 / ebytes;
    sh      = 64 - 8 * ebytes;
    emask   = (ebytes == 8) ? '1 : (64'd1 << (8 * ebytes)) - 64'd1;
    r.id    = insn.id;
    r.addr  = valu_pkg::vaddr_t'(insn.vd * `VALU_WORDS_PER_VREG + widx);
    r.wdata = '0;
    r.be    = '0;
    for (int unsigned e = 0; e < nelem; e++) begin
      x = insn.use_scalar ? (insn.scalar_op & emask) : ((a >> (8 * ebytes * e)) & emask);
      y = (b >> (8 * ebytes * e)) & emask;
      // Signed order from the element placed at the top of the word
      lt_s = $signed(x << sh) < $signed(y << sh);
      lt_u = x < y;
      case (insn.op)
        valu_pkg::VAND:   z = x & y;
        valu_pkg::VOR:    z = x | y;
        valu_pkg::VXOR:   z = x ^ y;
        valu_pkg::VADD:   z = x + y;
        valu_pkg::VSUB:   z = y - x;
        valu_pkg::VRSUB:  z = x - y;
        valu_pkg::VMIN:   z = lt_s ? x : y;
        valu_pkg::VMINU:  z = lt_u ? x : y;
        valu_pkg::VMAX:   z = lt_s ? y : x;
        valu_pkg::VMAXU:  z = lt_u ? y : x;
        valu_pkg::VMERGE: z = (insn.vm || m[e * ebytes]) ? x : y;
        default:          z = '0;
      endcase
      r.wdata |= (z & emask) << (8 * ebytes * e);
      // Bytes of elements inside vl, filtered by the mask except for merge
      if (widx * nelem + e < insn.vl) begin
        for (int unsigned k = 0; k < ebytes; k++) begin
          r.be[e * ebytes + k] = insn.vm || insn.op == valu_pkg::VMERGE || m[e * ebytes + k];
        end
      end
    end
    return r;
  endfunction

  task automatic note_failure(input string msg);
    errors++;
    $display("%s: %s", cur_test, msg);
  endtask

  task automatic check_result(
    input string                  name,
    input valu_pkg::valu_result_t exp,
    input valu_pkg::valu_result_t act
  );
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected id=%0d addr=%0d wdata=%h be=%b, actual id=%0d addr=%0d wdata=%h be=%b",
               name, exp.id, exp.addr, exp.wdata, exp.be, act.id, act.addr, act.wdata, act.be);
    end
  endtask

  task automatic check_done(
    input string                   name,
    input valu_pkg::vid_t          exp_id,
    input logic [`VALU_NR_IDS-1:0] act
  );
    logic [`VALU_NR_IDS-1:0] exp_vec;
    exp_vec = '0;
    exp_vec[exp_id] = 1'b1;
    checks++;
    if (act !== exp_vec) begin
      errors++;
      $display("ERR %s: expected done=%b, actual done=%b", name, exp_vec, act);
    end
  endtask

  // Queue one instruction with its operand words and expected results
  task automatic add_insn(input valu_pkg::valu_insn_t insn);
    int unsigned nelem;
    int unsigned nwords;
    valu_pkg::elen_t a, b;
    valu_pkg::strb_t m;
    nelem  = 8 / elem_bytes(insn.vsew);
    nwords = (insn.vl + nelem - 1) / nelem;
    for (int unsigned w = 0; w < nwords; w++) begin
      a = rand_word();
      b = rand_word();
      m = '1;
      if (!insn.vm) begin
        m = valu_pkg::strb_t'(lcg_next());
        m_q.push_back(m);
      end
      if (!insn.use_scalar) a_q.push_back(a);
      b_q.push_back(b);
      exp_res_q.push_back(model_word(insn, a, b, m, w));
    end
    exp_done_q.push_back(insn.id);
    insn_q.push_back(insn);
  endtask

  // Until every word is taken and every response seen; the watchdog bounds it
  task automatic wait_idle();
    do @(negedge clk_i);
    while (insn_q.size() != 0 || a_q.size() != 0 || b_q.size() != 0 || m_q.size() != 0
           || exp_res_q.size() != 0 || exp_done_q.size() != 0);
    repeat (2) @(negedge clk_i);
  endtask

  task automatic start_test(input string name);
    @(posedge clk_i);
    cur_test      = name;
    errors_before = errors;
    tests++;
  endtask

  task automatic end_test();
    wait_idle();
    $display("%-18s %s, %0d errors", cur_test,
             (errors == errors_before) ? "ok" : "failed", errors - errors_before);
  endtask

  task automatic reset_state_test();
    start_test("reset_state");
    @(negedge clk_i);
    checks++;
    if (!insn_ready_o || result_req_o || operand_a_ready_o || operand_b_ready_o
        || mask_ready_o || done_o != '0) begin
      note_failure("outputs after reset are not idle with insn_ready_o high");
    end
    end_test();
  endtask

  task automatic logic_add_test();
    start_test("logic_add_ew64");
    add_insn(make_insn(3'd1, valu_pkg::VAND, valu_pkg::EW64, 9'd4, 5'd3, 1'b1));
    add_insn(make_insn(3'd2, valu_pkg::VXOR, valu_pkg::EW64, 9'd4, 5'd4, 1'b1));
    add_insn(make_insn(3'd3, valu_pkg::VOR, valu_pkg::EW64, 9'd4, 5'd5, 1'b1));
    add_insn(make_insn(3'd4, valu_pkg::VADD, valu_pkg::EW64, 9'd4, 5'd31, 1'b1));
    end_test();
  endtask

  // 13 bytes leave a tail of 5 in the second word
  task automatic sub_rsub_test();
    start_test("sub_rsub_ew8");
    add_insn(make_insn(3'd4, valu_pkg::VSUB, valu_pkg::EW8, 9'd13, 5'd7, 1'b1));
    add_insn(make_insn(3'd5, valu_pkg::VRSUB, valu_pkg::EW8, 9'd13, 5'd8, 1'b1));
    end_test();
  endtask

  // Scalar has its lane sign bit set and junk above the element
  task automatic minmax_scalar_test();
    valu_pkg::elen_t s;
    s = 64'h1234_5678_0000_9c35;
    start_test("minmax_scalar_ew16");
    add_insn(make_insn(3'd6, valu_pkg::VMIN, valu_pkg::EW16, 9'd8, 5'd9, 1'b1, s, 1'b1));
    add_insn(make_insn(3'd7, valu_pkg::VMINU, valu_pkg::EW16, 9'd8, 5'd10, 1'b1, s, 1'b1));
    add_insn(make_insn(3'd0, valu_pkg::VMAX, valu_pkg::EW16, 9'd8, 5'd11, 1'b1, s, 1'b1));
    add_insn(make_insn(3'd1, valu_pkg::VMAXU, valu_pkg::EW16, 9'd7, 5'd12, 1'b1, s, 1'b1));
    end_test();
  endtask

  task automatic masked_test();
    start_test("masked_ew32");
    add_insn(make_insn(3'd2, valu_pkg::VADD, valu_pkg::EW32, 9'd5, 5'd13, 1'b0));
    add_insn(make_insn(3'd3, valu_pkg::VMERGE, valu_pkg::EW32, 9'd4, 5'd14, 1'b0));
    end_test();
  endtask

  // Two-word instructions, FIFO takes two words then everything stalls
  task automatic backpressure_test();
    start_test("backpressure");
    hold_gnt = 1'b1;
    for (int unsigned i = 0; i < 5; i++) begin
      add_insn(make_insn(valu_pkg::vid_t'(3 + i), valu_pkg::VADD, valu_pkg::EW64, 9'd2,
                         valu_pkg::vreg_t'(16 + i), 1'b1));
    end
    do @(negedge clk_i);
    while (insn_q.size() > 1);
    repeat (8) begin
      @(negedge clk_i);
      checks++;
      if (insn_ready_o || insn_q.size() != 1) begin
        note_failure("a fifth instruction was taken while four were held");
      end
      if (b_q.size() != 8) begin
        note_failure("operand words were taken while the result FIFO was full");
      end
    end
    @(posedge clk_i);
    hold_gnt = 1'b0;
    end_test();
  endtask

  initial begin : main
    rst_ni            = 1'b0;
    insn_i            = '0;
    insn_valid_i      = 1'b0;
    operand_a_i       = '0;
    operand_a_valid_i = 1'b0;
    operand_b_i       = '0;
    operand_b_valid_i = 1'b0;
    mask_i            = '0;
    mask_valid_i      = 1'b0;
    result_gnt_i      = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    reset_state_test();
    logic_add_test();
    sub_rsub_test();
    minmax_scalar_test();
    masked_test();
    backpressure_test();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== hw/valu_top.sv ====
// Vector ALU top; operand, mask and result strobes are single-cycle handshakes and gnt only while req
`timescale 1ns/1ps

module valu_top (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  valu_pkg::valu_insn_t                     insn_i,
  input  logic                                     insn_valid_i,
  output logic                                     insn_ready_o,
  input  valu_pkg::elen_t                          operand_a_i,
  input  logic                                     operand_a_valid_i,
  output logic                                     operand_a_ready_o,
  input  valu_pkg::elen_t                          operand_b_i,
  input  logic                                     operand_b_valid_i,
  output logic                                     operand_b_ready_o,
  input  valu_pkg::strb_t                          mask_i,
  input  logic                                     mask_valid_i,
  output logic                                     mask_ready_o,
  output valu_pkg::valu_result_t                   result_o,
  output logic                                     result_req_o,
  input  logic                                     result_gnt_i,
  output logic [2**$bits(valu_pkg::vid_t)-1:0]     done_o
);

  // Head of the issue side
  valu_pkg::valu_insn_t   issue_insn;
  logic                   issue_valid;
  logic                   issue_done;
  // Issue stage into result FIFO
  logic                   push;
  valu_pkg::valu_result_t push_data;
  logic                   fifo_full;

  insn_queue i_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .issue_done_i  (issue_done),
    .result_gnt_i  (result_gnt_i),
    .insn_ready_o  (insn_ready_o),
    .issue_insn_o  (issue_insn),
    .issue_valid_o (issue_valid),
    .done_o        (done_o)
  );

  valu_issue i_valu_issue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .issue_insn_i      (issue_insn),
    .issue_valid_i     (issue_valid),
    .operand_a_i       (operand_a_i),
    .operand_a_valid_i (operand_a_valid_i),
    .operand_b_i       (operand_b_i),
    .operand_b_valid_i (operand_b_valid_i),
    .mask_i            (mask_i),
    .mask_valid_i      (mask_valid_i),
    .fifo_full_i       (fifo_full),
    .operand_a_ready_o (operand_a_ready_o),
    .operand_b_ready_o (operand_b_ready_o),
    .mask_ready_o      (mask_ready_o),
    .issue_done_o      (issue_done),
    .push_o            (push),
    .push_data_o       (push_data)
  );

  // Grant pops the head word of the FIFO
  result_fifo #(
    .payload_t (valu_pkg::valu_result_t)
  ) i_result_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (result_gnt_i),
    .full_o      (fifo_full),
    .req_o       (result_req_o),
    .data_o      (result_o)
  );

endmodule

// ==== hw/valu_issue.sv ====
// Issue stage; one word per cycle, operands and mask are consumed together in the cycle ready is high
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_issue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  valu_pkg::valu_insn_t   issue_insn_i,
  input  logic                   issue_valid_i,
  input  valu_pkg::elen_t        operand_a_i,
  input  logic                   operand_a_valid_i,
  input  valu_pkg::elen_t        operand_b_i,
  input  logic                   operand_b_valid_i,
  input  valu_pkg::strb_t        mask_i,
  input  logic                   mask_valid_i,
  input  logic                   fifo_full_i,
  output logic                   operand_a_ready_o,
  output logic                   operand_b_ready_o,
  output logic                   mask_ready_o,
  output logic                   issue_done_o,
  output logic                   push_o,
  output valu_pkg::valu_result_t push_data_o
);

  // rem_q is only meaningful once the head has issued a word
  logic            active_q, active_d;
  valu_pkg::vlen_t rem_q, rem_d;
  valu_pkg::vlen_t remaining, per_word, elem_cnt, word_idx;
  logic [3:0]      nbytes;
  valu_pkg::strb_t tail_be, keep_be, alu_mask;
  valu_pkg::elen_t scalar_rep, alu_a, alu_res;
  logic            fire, last;

  // Fresh head takes its count straight from vl
  assign remaining = active_q ? rem_q : issue_insn_i.vl;
  assign per_word  = valu_pkg::vlen_t'(9'd8 >> issue_insn_i.vsew);
  assign last      = (remaining <= per_word);
  assign elem_cnt  = last ? remaining : per_word;
  assign nbytes    = 4'(elem_cnt << issue_insn_i.vsew);
  assign word_idx  = (issue_insn_i.vl - remaining) >> (2'd3 - issue_insn_i.vsew);

  // Bytes of the elements present in this word
  always_comb begin
    for (int unsigned b = 0; b < 8; b++) begin
      tail_be[b] = (4'(b) < nbytes);
    end
  end

  // Scalar copied into every lane
  always_comb begin
    case (issue_insn_i.vsew)
      valu_pkg::EW8:  scalar_rep = {8{issue_insn_i.scalar_op[7:0]}};
      valu_pkg::EW16: scalar_rep = {4{issue_insn_i.scalar_op[15:0]}};
      valu_pkg::EW32: scalar_rep = {2{issue_insn_i.scalar_op[31:0]}};
      default:        scalar_rep = issue_insn_i.scalar_op;
    endcase
  end

  assign alu_a    = issue_insn_i.use_scalar ? scalar_rep : operand_a_i;
  assign alu_mask = issue_insn_i.vm ? '1 : mask_i;
  // Merge writes every lane, the mask only picks the source
  assign keep_be  = (issue_insn_i.vm || issue_insn_i.op == valu_pkg::VMERGE) ? '1 : mask_i;

  simd_alu i_simd_alu (
    .operand_a_i (alu_a),
    .operand_b_i (operand_b_i),
    .mask_i      (alu_mask),
    .op_i        (issue_insn_i.op),
    .vsew_i      (issue_insn_i.vsew),
    .result_o    (alu_res)
  );

  // Everything the head needs is here and there is room
  assign fire = issue_valid_i && !fifo_full_i && operand_b_valid_i
              && (operand_a_valid_i || issue_insn_i.use_scalar)
              && (mask_valid_i || issue_insn_i.vm);

  assign operand_a_ready_o = fire && !issue_insn_i.use_scalar;
  assign operand_b_ready_o = fire;
  assign mask_ready_o      = fire && !issue_insn_i.vm;
  assign push_o            = fire;
  assign issue_done_o      = fire && last;

  assign push_data_o.id    = issue_insn_i.id;
  assign push_data_o.addr  = valu_pkg::vaddr_t'(issue_insn_i.vd)
                           * valu_pkg::vaddr_t'(`VALU_WORDS_PER_VREG)
                           + valu_pkg::vaddr_t'(word_idx);
  assign push_data_o.wdata = alu_res;
  assign push_data_o.be    = tail_be & keep_be;

  always_comb begin
    active_d = active_q;
    rem_d    = rem_q;
    if (fire) begin
      active_d = !last;
      rem_d    = remaining - elem_cnt;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      rem_q    <= '0;
    end else begin
      active_q <= active_d;
      rem_q    <= rem_d;
    end
  end

  // A head always has elements left to issue
  a_rem_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_i |-> remaining != '0);
  // Queue holds the head steady until its last word is issued
  a_head_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_i && !issue_done_o |=> issue_valid_i && $stable(issue_insn_i));

endmodule

// ==== hw/insn_queue.sv ====
// Instruction queue; vl must be 1..VALU_MAX_VL and results must be granted in issue order
`timescale 1ns/1ps
`include "valu_settings.svh"

module insn_queue (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  valu_pkg::valu_insn_t        insn_i,
  input  logic                        insn_valid_i,
  input  logic                        issue_done_i,
  input  logic                        result_gnt_i,
  output logic                        insn_ready_o,
  output valu_pkg::valu_insn_t        issue_insn_o,
  output logic                        issue_valid_o,
  output logic [`VALU_NR_IDS-1:0]     done_o
);

  localparam int unsigned Depth = `VALU_INSN_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);
  localparam int unsigned CntW  = $clog2(Depth + 1);

  valu_pkg::valu_insn_t insn_q [Depth];
  // Three pointers walk the same ring
  logic [PtrW-1:0] accept_ptr_q, accept_ptr_d;
  logic [PtrW-1:0] issue_ptr_q, issue_ptr_d;
  logic [PtrW-1:0] commit_ptr_q, commit_ptr_d;
  // Instructions still to issue and still to commit
  logic [CntW-1:0] issue_cnt_q, issue_cnt_d;
  logic [CntW-1:0] commit_cnt_q, commit_cnt_d;
  // Elements of the commit head not yet granted
  valu_pkg::vlen_t commit_left_q, commit_left_d;
  valu_pkg::vlen_t commit_per_word;
  valu_pkg::valu_insn_t commit_insn;
  logic accept;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + PtrW'(1);
  endfunction

  assign insn_ready_o    = (commit_cnt_q != CntW'(Depth));
  assign accept          = insn_valid_i && insn_ready_o;
  assign issue_insn_o    = insn_q[issue_ptr_q];
  assign issue_valid_o   = (issue_cnt_q != '0);
  assign commit_insn     = insn_q[commit_ptr_q];
  assign commit_per_word = valu_pkg::vlen_t'(9'd8 >> commit_insn.vsew);

  always_comb begin
    accept_ptr_d  = accept_ptr_q;
    issue_ptr_d   = issue_ptr_q;
    commit_ptr_d  = commit_ptr_q;
    issue_cnt_d   = issue_cnt_q;
    commit_cnt_d  = commit_cnt_q;
    commit_left_d = commit_left_q;
    done_o        = '0;

    // Last word of the issue head has left
    if (issue_done_i) begin
      issue_ptr_d = next_ptr(issue_ptr_q);
      issue_cnt_d = issue_cnt_q - CntW'(1);
    end

    // Each granted word retires up to one word of elements
    if (result_gnt_i && commit_cnt_q != '0) begin
      commit_left_d = (commit_left_q > commit_per_word) ? commit_left_q - commit_per_word : '0;
      if (commit_left_d == '0) begin
        done_o[commit_insn.id] = 1'b1;
        commit_ptr_d = next_ptr(commit_ptr_q);
        commit_cnt_d = commit_cnt_q - CntW'(1);
        // Next commit head is already stored
        if (commit_cnt_d != '0) begin
          commit_left_d = insn_q[commit_ptr_d].vl;
        end
      end
    end

    if (accept) begin
      // Empty commit side, so the new one becomes its head
      if (commit_cnt_d == '0) begin
        commit_left_d = insn_i.vl;
      end
      accept_ptr_d = next_ptr(accept_ptr_q);
      issue_cnt_d  = issue_cnt_d + CntW'(1);
      commit_cnt_d = commit_cnt_d + CntW'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_ptr_q  <= '0;
      issue_ptr_q   <= '0;
      commit_ptr_q  <= '0;
      issue_cnt_q   <= '0;
      commit_cnt_q  <= '0;
      commit_left_q <= '0;
    end else begin
      accept_ptr_q  <= accept_ptr_d;
      issue_ptr_q   <= issue_ptr_d;
      commit_ptr_q  <= commit_ptr_d;
      issue_cnt_q   <= issue_cnt_d;
      commit_cnt_q  <= commit_cnt_d;
      commit_left_q <= commit_left_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_ptr_q] <= insn_i;
    end
  end

  // Ring never overflows and nothing commits before it issues
  a_cnt_bounds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_cnt_q <= CntW'(Depth) && issue_cnt_q <= commit_cnt_q);
  a_vl_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> insn_i.vl != '0 && insn_i.vl <= valu_pkg::vlen_t'(`VALU_MAX_VL));
  // The issue stage only finishes a head that exists
  a_done_has_head: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_done_i |-> issue_valid_o);

endmodule

// ==== hw/result_fifo.sv ====
// Result FIFO of VALU_RESULT_DEPTH entries; caller must not push when full or pop when empty
`timescale 1ns/1ps
`include "valu_settings.svh"

module result_fifo #(
  parameter type payload_t = valu_pkg::valu_result_t
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t push_data_i,
  input  logic     pop_i,
  output logic     full_o,
  output logic     req_o,
  output payload_t data_o
);

  localparam int unsigned Depth = `VALU_RESULT_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] cnt_q;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + PtrW'(1);
  endfunction

  assign full_o = (cnt_q == CntW'(Depth));
  // Request is raised by the registered count, a cycle after the push
  assign req_o  = (cnt_q != '0);
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop_i) rd_ptr_q <= next_ptr(rd_ptr_q);
      // Simultaneous push and pop keep the count
      cnt_q <= cnt_q + CntW'(push_i) - CntW'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> req_o);

endmodule

// ==== simd_alu/simd_alu.sv ====
// Combinational SIMD ALU; mask_i is all ones for unmasked ops and only merge reads it
`timescale 1ns/1ps

module simd_alu (
  input  valu_pkg::elen_t   operand_a_i,
  input  valu_pkg::elen_t   operand_b_i,
  input  valu_pkg::strb_t   mask_i,
  input  valu_pkg::alu_op_e op_i,
  input  valu_pkg::vsew_e   vsew_i,
  output valu_pkg::elen_t   result_o
);

  // Lane width in bits and number of lanes
  logic [6:0]      lane_bits;
  logic [3:0]      nr_lanes;
  valu_pkg::elen_t lane_mask, sign_bit;
  logic            is_signed;

  assign lane_bits = 7'd8 << vsew_i;
  assign nr_lanes  = 4'd8 >> vsew_i;
  assign lane_mask = (vsew_i == valu_pkg::EW64) ? '1 : ((64'd1 << lane_bits) - 64'd1);
  assign is_signed = (op_i == valu_pkg::VMIN) || (op_i == valu_pkg::VMAX);
  // Flipping the lane sign bit turns a signed compare into an unsigned one
  assign sign_bit  = is_signed ? (64'd1 << (lane_bits - 7'd1)) : '0;

  // One lane, operands zero extended, upper bits dropped by the caller
  function automatic valu_pkg::elen_t lane_op(
    input valu_pkg::elen_t   a,
    input valu_pkg::elen_t   b,
    input logic              m,
    input valu_pkg::alu_op_e op,
    input valu_pkg::elen_t   sbit
  );
    logic less;
    less = ((a ^ sbit) < (b ^ sbit));
    case (op)
      valu_pkg::VAND:   return a & b;
      valu_pkg::VOR:    return a | b;
      valu_pkg::VXOR:   return a ^ b;
      valu_pkg::VADD:   return a + b;
      // vs2 minus vs1 for sub, reversed for rsub
      valu_pkg::VSUB:   return b - a;
      valu_pkg::VRSUB:  return a - b;
      valu_pkg::VMIN,
      valu_pkg::VMINU:  return less ? a : b;
      valu_pkg::VMAX,
      valu_pkg::VMAXU:  return less ? b : a;
      valu_pkg::VMERGE: return m ? a : b;
      default:          return '0;
    endcase
  endfunction

  always_comb begin : p_lanes
    valu_pkg::elen_t a_lane;
    valu_pkg::elen_t b_lane;
    valu_pkg::elen_t r_lane;
    logic            m_lane;
    a_lane   = '0;
    b_lane   = '0;
    r_lane   = '0;
    m_lane   = 1'b0;
    result_o = '0;
    for (int unsigned i = 0; i < 8; i++) begin
      if (i < nr_lanes) begin
        a_lane   = (operand_a_i >> (i * lane_bits)) & lane_mask;
        b_lane   = (operand_b_i >> (i * lane_bits)) & lane_mask;
        // Lowest mask bit of the element decides merge
        m_lane   = mask_i[i << vsew_i];
        r_lane   = lane_op(a_lane, b_lane, m_lane, op_i, sign_bit);
        result_o = result_o | ((r_lane & lane_mask) << (i * lane_bits));
      end
    end
  end

endmodule

// ==== common/valu_pkg.sv ====
// Types of the vector ALU; widths assume a 64-bit datapath and at most 256 elements per vector
package valu_pkg;

  // One datapath word and its byte enables
  typedef logic [63:0] elen_t;
  typedef logic [7:0]  strb_t;

  // Element width, the encoding doubles as log2 of the element bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  typedef enum logic [3:0] {
    VAND, VOR, VXOR,
    VADD, VSUB, VRSUB,
    VMIN, VMINU, VMAX, VMAXU,
    VMERGE
  } alu_op_e;

  typedef logic [2:0] vid_t;
  typedef logic [8:0] vlen_t;
  typedef logic [9:0] vaddr_t;
  typedef logic [4:0] vreg_t;

  typedef struct packed {
    vid_t    id;
    alu_op_e op;
    vsew_e   vsew;
    vlen_t   vl;
    vreg_t   vd;
    elen_t   scalar_op;
    logic    use_scalar;
    // Set for an unmasked instruction
    logic    vm;
  } valu_insn_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } valu_result_t;

endpackage

// ==== common/valu_settings.svh ====
// Sizing of the vector ALU; vlen_t in valu_pkg must hold VALU_MAX_VL and vid_t must cover VALU_NR_IDS
`ifndef VALU_SETTINGS_SVH
`define VALU_SETTINGS_SVH

// Instructions held between accept and commit
`define VALU_INSN_DEPTH 4

// Result words waiting for a register file grant
`define VALU_RESULT_DEPTH 2

// Longest vector in elements
`define VALU_MAX_VL 256

// 64-bit words in one vector register
`define VALU_WORDS_PER_VREG 32

// One done bit per instruction id
`define VALU_NR_IDS 8

`endif
